// File: src/fe_defines.svh
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// byte address width of fetch PCs and instruction memory addresses
`define FE_ADDR_W 32

// one instruction word
`define FE_INSTR_W 32

// AXI4-Lite register port
`define FE_AXI_ADDR_W 8
`define FE_AXI_DATA_W 32

// checker event counters
`define FE_CNT_W 32

`endif

// File: src/instr_pkg.sv
package instr_pkg;

    // coarse instruction class, taken from the major opcode field
    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JUMP,
        OP_SYSTEM,
        OP_OTHER
    } t_opcode;

    localparam logic [6:0] MAJ_OP_IMM = 7'h13;  // alu with immediate
    localparam logic [6:0] MAJ_OP     = 7'h33;  // alu register-register
    localparam logic [6:0] MAJ_LOAD   = 7'h03;
    localparam logic [6:0] MAJ_STORE  = 7'h23;
    localparam logic [6:0] MAJ_BRANCH = 7'h63;
    localparam logic [6:0] MAJ_JAL    = 7'h6F;
    localparam logic [6:0] MAJ_JALR   = 7'h67;
    localparam logic [6:0] MAJ_SYSTEM = 7'h73;

endpackage

// File: src/fe_ctl_pkg.sv
`include "fe_defines.svh"

package fe_ctl_pkg;

    // fetch stream checker states
    typedef enum logic [1:0] {
        CHK_IDLE,          // no sequence base yet
        CHK_SEQ,           // expecting previous pc + 4
        CHK_PDG_REDIRECT   // waiting for first accept at redirect target
    } t_chk_state;

    // register offsets on the AXI4-Lite port
    typedef enum logic [`FE_AXI_ADDR_W-1:0] {
        CSR_CTRL         = 8'h00,  // bit 0 enable
        CSR_BOOT_PC      = 8'h04,
        CSR_FETCH_CNT    = 8'h08,  // read only
        CSR_MISMATCH_CNT = 8'h0C,  // read only
        CSR_EXP_PC       = 8'h10   // read only
    } t_csr_addr;

endpackage

// File: src/fe_csr.sv
`timescale 1ns/100ps
`include "fe_defines.svh"

module fe_csr (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`FE_AXI_ADDR_W-1:0]    awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`FE_AXI_DATA_W-1:0]    wdata,
    input  logic [`FE_AXI_DATA_W/8-1:0]  wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [`FE_AXI_ADDR_W-1:0]    araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`FE_AXI_DATA_W-1:0]    rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    input  logic [`FE_CNT_W-1:0]         fetch_cnt,
    input  logic [`FE_CNT_W-1:0]         mismatch_cnt,
    input  logic [`FE_ADDR_W-1:0]        exp_pc,
    output logic                         fetch_en,
    output logic [`FE_ADDR_W-1:0]        boot_pc
);
    logic                      wr_rdy;
    logic                      wr_go;
    logic                      rd_go;
    logic [`FE_AXI_DATA_W-1:0] rd_mux;

    assign awready = wr_rdy;  // address and data taken together
    assign wready  = wr_rdy;
    assign wr_go   = wr_rdy & awvalid & wvalid;
    assign rd_go   = arready & arvalid;
    assign bresp   = 2'b00;   // always OKAY
    assign rresp   = 2'b00;

    always_comb begin
        case (fe_ctl_pkg::t_csr_addr'(araddr))
            fe_ctl_pkg::CSR_CTRL:         rd_mux = {{(`FE_AXI_DATA_W-1){1'b0}}, fetch_en};
            fe_ctl_pkg::CSR_BOOT_PC:      rd_mux = boot_pc;
            fe_ctl_pkg::CSR_FETCH_CNT:    rd_mux = fetch_cnt;
            fe_ctl_pkg::CSR_MISMATCH_CNT: rd_mux = mismatch_cnt;
            fe_ctl_pkg::CSR_EXP_PC:       rd_mux = exp_pc;
            default:                      rd_mux = '0;  // unmapped reads zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_rdy   <= 1'b0;
            bvalid   <= 1'b0;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            fetch_en <= 1'b0;
            boot_pc  <= '0;
        end else begin
            wr_rdy  <= awvalid & wvalid & ~wr_rdy & ~bvalid;  // single cycle pulse
            arready <= arvalid & ~arready & ~rvalid;

            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;  // response held until taken
            end

            if (rd_go) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            if (wr_go) begin
                case (fe_ctl_pkg::t_csr_addr'(awaddr))
                    fe_ctl_pkg::CSR_CTRL: begin
                        if (wstrb[0]) fetch_en <= wdata[0];
                    end
                    fe_ctl_pkg::CSR_BOOT_PC: begin
                        for (int b = 0; b < `FE_AXI_DATA_W/8; b++) begin
                            if (wstrb[b]) boot_pc[b*8 +: 8] <= wdata[b*8 +: 8];
                        end
                    end
                    default: ;  // read-only or unmapped, write ignored
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) rdata <= rd_mux;  // sampled at address handshake
    end

endmodule

// File: src/fetch_pc_gen.sv
`timescale 1ns/100ps
`include "fe_defines.svh"

module fetch_pc_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_en,
    input  logic [`FE_ADDR_W-1:0]   boot_pc,
    input  logic [`FE_INSTR_W-1:0]  imem_rdata,
    input  logic                    decode_ready,
    input  logic                    br_mispred_valid,
    input  logic [`FE_ADDR_W-1:0]   br_restore_pc,
    input  logic                    nuke_valid,
    input  logic [`FE_ADDR_W-1:0]   nuke_pc,
    output logic                    imem_req,
    output logic [`FE_ADDR_W-1:0]   imem_addr,
    output logic                    instr_valid,
    output logic [`FE_ADDR_W-1:0]   instr_pc,
    output logic [`FE_INSTR_W-1:0]  instr_raw,
    output instr_pkg::t_opcode      instr_op
);
    logic                    active_q;
    logic                    start;
    logic                    redirect;
    logic [`FE_ADDR_W-1:0]   redirect_pc;
    logic [`FE_ADDR_W-1:0]   fetch_pc;
    logic                    valid_fe1;
    logic                    fresh_fe1;   // memory data arrives this cycle
    logic [`FE_ADDR_W-1:0]   pc_fe1;
    logic [`FE_INSTR_W-1:0]  raw_fe1;

    assign start       = fetch_en & ~active_q;
    assign redirect    = br_mispred_valid | nuke_valid;
    assign redirect_pc = nuke_valid ? nuke_pc : br_restore_pc;  // nuke wins

    // request when fe1 is empty or being drained this cycle
    assign imem_req  = active_q & fetch_en & ~redirect & (~valid_fe1 | decode_ready);
    assign imem_addr = fetch_pc;

    assign instr_valid = valid_fe1 & ~redirect;  // redirect discards fe1
    assign instr_pc    = pc_fe1;
    assign instr_raw   = fresh_fe1 ? imem_rdata : raw_fe1;

    always_comb begin
        case (instr_raw[6:0])
            instr_pkg::MAJ_OP_IMM,
            instr_pkg::MAJ_OP:     instr_op = instr_pkg::OP_ALU;
            instr_pkg::MAJ_LOAD:   instr_op = instr_pkg::OP_LOAD;
            instr_pkg::MAJ_STORE:  instr_op = instr_pkg::OP_STORE;
            instr_pkg::MAJ_BRANCH: instr_op = instr_pkg::OP_BRANCH;
            instr_pkg::MAJ_JAL,
            instr_pkg::MAJ_JALR:   instr_op = instr_pkg::OP_JUMP;
            instr_pkg::MAJ_SYSTEM: instr_op = instr_pkg::OP_SYSTEM;
            default:               instr_op = instr_pkg::OP_OTHER;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q  <= 1'b0;
            fresh_fe1 <= 1'b0;
            valid_fe1 <= 1'b0;
            fetch_pc  <= '0;
        end else begin
            active_q  <= fetch_en;
            fresh_fe1 <= imem_req;  // dropped requests never reach fe1

            if (!fetch_en || redirect) begin
                valid_fe1 <= 1'b0;
            end else if (imem_req) begin
                valid_fe1 <= 1'b1;
            end else if (decode_ready) begin
                valid_fe1 <= 1'b0;
            end

            if (start) begin
                fetch_pc <= boot_pc;
            end else if (redirect) begin
                fetch_pc <= redirect_pc;
            end else if (imem_req) begin
                fetch_pc <= fetch_pc + `FE_ADDR_W'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req) pc_fe1 <= fetch_pc;
        if (fresh_fe1) raw_fe1 <= imem_rdata;  // keep word across a stall
    end

endmodule

// File: src/fetch_chk.sv
`timescale 1ns/100ps
`include "fe_defines.svh"

module fetch_chk (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_en,
    input  logic                   instr_valid,
    input  logic [`FE_ADDR_W-1:0]  instr_pc,
    input  logic                   decode_ready,
    input  logic                   br_mispred_valid,
    input  logic [`FE_ADDR_W-1:0]  br_restore_pc,
    input  logic                   nuke_valid,
    input  logic [`FE_ADDR_W-1:0]  nuke_pc,
    input  logic [`FE_ADDR_W-1:0]  boot_pc,
    output logic [`FE_CNT_W-1:0]   fetch_cnt,
    output logic [`FE_CNT_W-1:0]   mismatch_cnt,
    output logic [`FE_ADDR_W-1:0]  exp_pc
);
    fe_ctl_pkg::t_chk_state  state;
    logic                    redirect;
    logic [`FE_ADDR_W-1:0]   redirect_pc;
    logic                    accept;
    logic [`FE_ADDR_W-1:0]   seq_pc;

    assign redirect    = br_mispred_valid | nuke_valid;
    assign redirect_pc = nuke_valid ? nuke_pc : br_restore_pc;
    assign accept      = instr_valid & decode_ready & ~redirect;
    assign seq_pc      = instr_pc + `FE_ADDR_W'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= fe_ctl_pkg::CHK_IDLE;
            exp_pc       <= '0;
            fetch_cnt    <= '0;
            mismatch_cnt <= '0;
        end else begin
            if (accept) fetch_cnt <= fetch_cnt + 1'b1;

            // first accept after idle only sets the base
            if (accept && state != fe_ctl_pkg::CHK_IDLE && instr_pc != exp_pc) begin
                mismatch_cnt <= mismatch_cnt + 1'b1;
            end

            if (!fetch_en) begin
                state <= fe_ctl_pkg::CHK_IDLE;
                if (accept) exp_pc <= seq_pc;  // last word drained while disabling
            end else if (redirect) begin
                state  <= fe_ctl_pkg::CHK_PDG_REDIRECT;
                exp_pc <= redirect_pc;
            end else begin
                case (state)
                    fe_ctl_pkg::CHK_IDLE: begin
                        if (accept) begin
                            state  <= fe_ctl_pkg::CHK_SEQ;
                            exp_pc <= seq_pc;
                        end else begin
                            exp_pc <= boot_pc;  // base until the first accept
                        end
                    end
                    fe_ctl_pkg::CHK_SEQ,
                    fe_ctl_pkg::CHK_PDG_REDIRECT: begin
                        if (accept) begin
                            state  <= fe_ctl_pkg::CHK_SEQ;
                            exp_pc <= seq_pc;
                        end
                    end
                    default: state <= fe_ctl_pkg::CHK_IDLE;
                endcase
            end
        end
    end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/100ps
`include "fe_defines.svh"

module fetch_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`FE_AXI_ADDR_W-1:0]    awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`FE_AXI_DATA_W-1:0]    wdata,
    input  logic [`FE_AXI_DATA_W/8-1:0]  wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [`FE_AXI_ADDR_W-1:0]    araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`FE_AXI_DATA_W-1:0]    rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output logic                         imem_req,
    output logic [`FE_ADDR_W-1:0]        imem_addr,
    input  logic [`FE_INSTR_W-1:0]       imem_rdata,
    output logic                         instr_valid,
    output logic [`FE_ADDR_W-1:0]        instr_pc,
    output logic [`FE_INSTR_W-1:0]       instr_raw,
    output instr_pkg::t_opcode           instr_op,
    input  logic                         decode_ready,
    input  logic                         br_mispred_valid,
    input  logic [`FE_ADDR_W-1:0]        br_restore_pc,
    input  logic                         nuke_valid,
    input  logic [`FE_ADDR_W-1:0]        nuke_pc
);
    logic                    fetch_en;
    logic [`FE_ADDR_W-1:0]   boot_pc;
    logic [`FE_CNT_W-1:0]    fetch_cnt;
    logic [`FE_CNT_W-1:0]    mismatch_cnt;
    logic [`FE_ADDR_W-1:0]   exp_pc;

    fe_csr u_csr (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .fetch_cnt, .mismatch_cnt, .exp_pc,
        .fetch_en, .boot_pc
    );

    fetch_pc_gen u_pc_gen (
        .clk, .reset, .fetch_en, .boot_pc,
        .imem_req, .imem_addr, .imem_rdata,
        .instr_valid, .instr_pc, .instr_raw, .instr_op, .decode_ready,
        .br_mispred_valid, .br_restore_pc, .nuke_valid, .nuke_pc
    );

    fetch_chk u_chk (
        .clk, .reset, .fetch_en,
        .instr_valid, .instr_pc, .decode_ready,
        .br_mispred_valid, .br_restore_pc, .nuke_valid, .nuke_pc, .boot_pc,
        .fetch_cnt, .mismatch_cnt, .exp_pc
    );

endmodule

// File: testbench/fetch_chk_checker.sv
`timescale 1ns/100ps
`include "fe_defines.svh"

module fetch_chk_checker (
    input logic                          clk,
    input logic                          reset,
    input logic                          fetch_en,
    input fe_ctl_pkg::t_chk_state        chk_state,
    input logic                          imem_req,
    input logic                          instr_valid,
    input logic [`FE_ADDR_W-1:0]         instr_pc,
    input logic [`FE_INSTR_W-1:0]        instr_raw,
    input instr_pkg::t_opcode            instr_op,
    input logic                          decode_ready,
    input logic                          awvalid,
    input logic                          awready,
    input logic                          wvalid,
    input logic                          wready,
    input logic                          bvalid,
    input logic                          bready,
    input logic                          arvalid,
    input logic                          arready,
    input logic                          rvalid,
    input logic                          rready,
    input logic [`FE_CNT_W-1:0]          fetch_cnt,
    input logic [`FE_CNT_W-1:0]          mismatch_cnt
);
    int fail_cnt = 0;  // count of failed assertions

    // a stalled instruction keeps its pc, word and class
    a_instr_hold: assert property (@(posedge clk) disable iff (reset)
        instr_valid && !decode_ready && fetch_en
        |=> $stable(instr_pc) && $stable(instr_raw) && $stable(instr_op))
    else begin
        fail_cnt++;
        $error("instr_* changed while decode was stalled");
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid)
    else begin
        fail_cnt++;
        $error("awvalid dropped before awready");
    end

    a_w_hold: assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid)
    else begin
        fail_cnt++;
        $error("wvalid dropped before wready");
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid)
    else begin
        fail_cnt++;
        $error("arvalid dropped before arready");
    end

    // responses wait for the master
    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
    else begin
        fail_cnt++;
        $error("bvalid dropped before bready");
    end

    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
    else begin
        fail_cnt++;
        $error("rvalid dropped before rready");
    end

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !imem_req && !instr_valid && !awready && !wready && !bvalid
            && !arready && !rvalid && !fetch_en && fetch_cnt == '0
            && mismatch_cnt == '0 && chk_state == fe_ctl_pkg::CHK_IDLE)
    else begin
        fail_cnt++;
        $error("control outputs not idle after reset");
    end

endmodule

bind fetch_top fetch_chk_checker u_checker (
    .clk, .reset, .fetch_en, .chk_state(u_chk.state),
    .imem_req, .instr_valid, .instr_pc, .instr_raw, .instr_op, .decode_ready,
    .awvalid, .awready, .wvalid, .wready, .bvalid, .bready,
    .arvalid, .arready, .rvalid, .rready,
    .fetch_cnt, .mismatch_cnt
);

// File: testbench/fetch_tb.sv
`timescale 1ns/100ps
`include "fe_defines.svh"

module fetch_tb;
    typedef struct packed {
        logic [`FE_ADDR_W-1:0] boot;
        logic [7:0]            count;     // accepts to collect
        logic [1:0]            kind;      // redirect source
        logic [7:0]            redir_at;  // redirect after this many accepts
        logic [`FE_ADDR_W-1:0] restore;
        logic                  bp;        // random decode back-pressure
    } row_t;

    localparam int NUM_ROWS    = 6;
    localparam int AXI_TIMEOUT = 50;
    localparam int KIND_NONE   = 0;
    localparam int KIND_BR     = 1;
    localparam int KIND_NUKE   = 2;
    localparam int KIND_BOTH   = 3;
    localparam logic [`FE_ADDR_W-1:0] DECOY_PC = 32'hDEAD_0000;

    logic                          clk;
    logic                          reset;
    logic [`FE_AXI_ADDR_W-1:0]     awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [`FE_AXI_DATA_W-1:0]     wdata;
    logic [`FE_AXI_DATA_W/8-1:0]   wstrb;
    logic                          wvalid;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [`FE_AXI_ADDR_W-1:0]     araddr;
    logic                          arvalid;
    logic                          arready;
    logic [`FE_AXI_DATA_W-1:0]     rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;
    logic                          imem_req;
    logic [`FE_ADDR_W-1:0]         imem_addr;
    logic [`FE_INSTR_W-1:0]        imem_rdata;
    logic                          instr_valid;
    logic [`FE_ADDR_W-1:0]         instr_pc;
    logic [`FE_INSTR_W-1:0]        instr_raw;
    instr_pkg::t_opcode            instr_op;
    logic                          decode_ready;
    logic                          br_mispred_valid;
    logic [`FE_ADDR_W-1:0]         br_restore_pc;
    logic                          nuke_valid;
    logic [`FE_ADDR_W-1:0]         nuke_pc;

    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr;
    logic        hung;
    int          checks;
    int          errors;
    int          total_acc;

    fetch_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic rand_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    // opcode cycles with the word index and the upper bits fold the address
    function automatic logic [`FE_INSTR_W-1:0] mem_word(input logic [`FE_ADDR_W-1:0] a);
        logic [6:0] maj;
        case ((a >> 2) % 9)
            0: maj = 7'h13;
            1: maj = 7'h03;
            2: maj = 7'h33;
            3: maj = 7'h23;
            4: maj = 7'h63;
            5: maj = 7'h6F;
            6: maj = 7'h73;
            7: maj = 7'h67;
            default: maj = 7'h0B;  // custom-0 opcode
        endcase
        return {a[24:0] ^ a[31:7], maj};
    endfunction

    function automatic instr_pkg::t_opcode op_of(input logic [`FE_INSTR_W-1:0] w);
        case (w[6:0])
            7'h13, 7'h33: return instr_pkg::OP_ALU;
            7'h03:        return instr_pkg::OP_LOAD;
            7'h23:        return instr_pkg::OP_STORE;
            7'h63:        return instr_pkg::OP_BRANCH;
            7'h6F, 7'h67: return instr_pkg::OP_JUMP;
            7'h73:        return instr_pkg::OP_SYSTEM;
            default:      return instr_pkg::OP_OTHER;
        endcase
    endfunction

    function automatic logic [31:0] merge_strb(input logic [31:0] old,
                                               input logic [31:0] d,
                                               input logic [3:0]  s);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b])
                r[b*8 +: 8] = d[b*8 +: 8];
        end
        return r;
    endfunction

    function automatic row_t make_row(input logic [31:0] boot, input int count,
                                      input int kind, input int at,
                                      input logic [31:0] restore, input logic bp);
        row_t t;
        t.boot     = boot;
        t.count    = count;
        t.kind     = kind;
        t.redir_at = at;
        t.restore  = restore;
        t.bp       = bp;
        return t;
    endfunction

    task automatic check_pc(input string what, input logic [`FE_ADDR_W-1:0] got,
                            input logic [`FE_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_op(input string what, input instr_pkg::t_opcode got,
                            input instr_pkg::t_opcode exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_raw(input string what, input logic [`FE_INSTR_W-1:0] got,
                             input logic [`FE_INSTR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input string what, input logic [`FE_AXI_DATA_W-1:0] got,
                             input logic [`FE_AXI_DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] got,
                              input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        hung = 1'b1;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic report_test(input string name, input int fails);
        if (fails == 0)
            $display("%s: ok", name);
        else
            $display("%s: %0d check(s) wrong", name, fails);
    endtask

    task automatic axi_write(input logic [`FE_AXI_ADDR_W-1:0] addr,
                             input logic [`FE_AXI_DATA_W-1:0] data,
                             input logic [`FE_AXI_DATA_W/8-1:0] strb);
        int n;
        if (hung)
            return;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        n = 0;
        while (!(awready && wready) && n < AXI_TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (n >= AXI_TIMEOUT) begin
            note_timeout($sformatf("write to %h was never accepted", addr));
            return;
        end
        bready = 1'b1;
        #1;
        n = 0;
        while (!bvalid && n < AXI_TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (n < AXI_TIMEOUT)
            check_resp("bresp", bresp, 2'b00);  // OKAY
        @(negedge clk);
        bready = 1'b0;
        if (n >= AXI_TIMEOUT)
            note_timeout($sformatf("write to %h got no response", addr));
    endtask

    task automatic axi_read(input logic [`FE_AXI_ADDR_W-1:0] addr,
                            output logic [`FE_AXI_DATA_W-1:0] data);
        int n;
        data = 'x;
        if (hung)
            return;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        n = 0;
        while (!arready && n < AXI_TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        if (n >= AXI_TIMEOUT) begin
            note_timeout($sformatf("read of %h was never accepted", addr));
            return;
        end
        rready = 1'b1;
        #1;
        n = 0;
        while (!rvalid && n < AXI_TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        data = rdata;  // taken at the next rising edge
        if (n < AXI_TIMEOUT)
            check_resp("rresp", rresp, 2'b00);
        @(negedge clk);
        rready = 1'b0;
        if (n >= AXI_TIMEOUT)
            note_timeout($sformatf("read of %h returned no data", addr));
    endtask

    // instruction memory answers one cycle after each request
    initial begin : imem_model
        logic                  req_q;
        logic [`FE_ADDR_W-1:0] addr_q;
        req_q      = 1'b0;
        addr_q     = '0;
        imem_rdata = '0;
        forever begin
            @(negedge clk);
            imem_rdata = req_q ? mem_word(addr_q) : '0;
            #1;
            req_q  = imem_req;
            addr_q = imem_addr;
        end
    end

    task automatic run_row(input int r);
        row_t                      row;
        logic [`FE_ADDR_W-1:0]     exp_pc;
        logic [`FE_ADDR_W-1:0]     last_pc;
        logic [`FE_AXI_DATA_W-1:0] rd;
        int                        acc;
        int                        n;
        int                        limit;
        int                        fails_before;
        logic                      redir_due;
        logic                      redir_done;
        row          = rows[r];
        fails_before = errors;
        exp_pc       = row.boot;
        last_pc      = '0;
        acc          = 0;
        n            = 0;
        limit        = 40 * row.count + 100;
        redir_due    = 1'b0;
        redir_done   = 1'b0;
        axi_write(fe_ctl_pkg::CSR_BOOT_PC, row.boot, 4'hF);
        axi_write(fe_ctl_pkg::CSR_CTRL, 32'h1, 4'h1);
        axi_read(fe_ctl_pkg::CSR_CTRL, rd);
        check_reg("ctrl after enable", rd, 32'h1);
        while (acc < row.count && n < limit && !hung) begin
            @(negedge clk);
            decode_ready     = row.bp ? rand_bit() : 1'b1;
            br_mispred_valid = 1'b0;
            nuke_valid       = 1'b0;
            if (redir_due) begin
                br_mispred_valid = (row.kind == KIND_BR) || (row.kind == KIND_BOTH);
                nuke_valid       = (row.kind == KIND_NUKE) || (row.kind == KIND_BOTH);
                br_restore_pc    = (row.kind == KIND_BR) ? row.restore : DECOY_PC;
                nuke_pc          = (row.kind == KIND_BR) ? DECOY_PC : row.restore;
                exp_pc           = row.restore;
                redir_due        = 1'b0;
                redir_done       = 1'b1;
            end
            #1;
            if (instr_valid && decode_ready) begin
                check_pc($sformatf("row %0d instr_pc", r), instr_pc, exp_pc);
                check_raw($sformatf("row %0d instr_raw", r), instr_raw, mem_word(exp_pc));
                check_op($sformatf("row %0d instr_op", r), instr_op, op_of(mem_word(exp_pc)));
                last_pc = exp_pc;
                exp_pc  = exp_pc + 4;
                acc++;
                if (row.kind != KIND_NONE && !redir_done && acc == row.redir_at)
                    redir_due = 1'b1;
            end
            n++;
        end
        if (acc < row.count && !hung)
            note_timeout($sformatf("row %0d stopped at %0d of %0d accepts", r, acc, row.count));
        total_acc += row.count;
        @(negedge clk);
        decode_ready     = 1'b0;  // nothing more leaves fe1
        br_mispred_valid = 1'b0;
        nuke_valid       = 1'b0;
        axi_write(fe_ctl_pkg::CSR_CTRL, 32'h0, 4'h1);
        axi_read(fe_ctl_pkg::CSR_FETCH_CNT, rd);
        check_reg("fetch_cnt", rd, total_acc);
        axi_read(fe_ctl_pkg::CSR_MISMATCH_CNT, rd);
        check_reg("mismatch_cnt", rd, 32'h0);
        axi_read(fe_ctl_pkg::CSR_EXP_PC, rd);
        check_reg("exp_pc", rd, last_pc + 4);
        report_test($sformatf("row %0d", r), errors - fails_before);
    endtask

    initial begin
        logic [`FE_AXI_DATA_W-1:0] rd;
        logic [`FE_AXI_DATA_W-1:0] boot_model;
        int                        fails_before;
        reset            = 1'b1;
        awaddr           = '0;
        awvalid          = 1'b0;
        wdata            = '0;
        wstrb            = '0;
        wvalid           = 1'b0;
        bready           = 1'b0;
        araddr           = '0;
        arvalid          = 1'b0;
        rready           = 1'b0;
        decode_ready     = 1'b0;
        br_mispred_valid = 1'b0;
        br_restore_pc    = '0;
        nuke_valid       = 1'b0;
        nuke_pc          = '0;
        lfsr             = 16'd12519;
        hung             = 1'b0;
        checks           = 0;
        errors           = 0;
        total_acc        = 0;

        //                  boot          count kind       at  restore       bp
        rows[0] = make_row(32'h0000_1000, 12,   KIND_NONE, 0,  32'h0,        1'b0);
        rows[1] = make_row(32'h0000_2000, 20,   KIND_NONE, 0,  32'h0,        1'b1);
        rows[2] = make_row(32'h0000_3000, 16,   KIND_BR,   5,  32'h0000_3400, 1'b0);
        rows[3] = make_row(32'h0000_4000, 16,   KIND_NUKE, 7,  32'h0000_0800, 1'b1);
        rows[4] = make_row(32'h0000_5000, 14,   KIND_BOTH, 3,  32'h0000_6000, 1'b1);
        rows[5] = make_row(32'h0001_7FF0, 10,   KIND_BR,   1,  32'h0000_9000, 1'b1);

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fails_before = errors;
        axi_write(fe_ctl_pkg::CSR_BOOT_PC, 32'hA5A5_A5A5, 4'hF);
        axi_read(fe_ctl_pkg::CSR_BOOT_PC, rd);
        check_reg("boot_pc", rd, 32'hA5A5_A5A5);
        boot_model = merge_strb(32'hA5A5_A5A5, 32'h1122_3344, 4'b0100);
        axi_write(fe_ctl_pkg::CSR_BOOT_PC, 32'h1122_3344, 4'b0100);
        axi_read(fe_ctl_pkg::CSR_BOOT_PC, rd);
        check_reg("boot_pc byte 2", rd, boot_model);
        axi_write(fe_ctl_pkg::CSR_CTRL, 32'h1, 4'h0);  // no strobe so enable stays off
        axi_read(fe_ctl_pkg::CSR_CTRL, rd);
        check_reg("ctrl", rd, 32'h0);
        axi_read(8'h14, rd);
        check_reg("offset 0x14", rd, 32'h0);
        axi_read(8'hFC, rd);
        check_reg("offset 0xfc", rd, 32'h0);
        report_test("register access", errors - fails_before);

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);

        errors += uut.u_checker.fail_cnt;
        $display("done: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, uut.u_checker.fail_cnt);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/instr_pkg.sv
src/fe_ctl_pkg.sv
src/fe_csr.sv
src/fetch_pc_gen.sv
src/fetch_chk.sv
src/fetch_top.sv
testbench/fetch_chk_checker.sv
testbench/fetch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the fetch front end testbench with Verilator, run it, scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module fetch_tb -o fetch_tb_sim

# let every assertion failure through so the testbench can count them
./obj_dir/fetch_tb_sim +verilator+error+limit+1000 | tee "$log"

if grep -q "Simulation failed" "$log"; then
    echo "run.sh: testbench reported a failure, see $log"
    exit 1
fi
echo "run.sh: no failure found in $log"
